// ==== Bender.yml ====
package:
  name: sd_host_write

sources:
  - common/sdPkg.sv
  - src/sdCrc7.sv
  - src/sdCrc16.sv
  - sdCore/sdCmdLink.sv
  - sdCore/sdDatWriter.sv
  - sdCore/sdWriteSequencer.sv
  - src/sdHostTop.sv
  - target: simulation
    files:
      - verif/sdCardModel.sv
      - verif/tbSdHost.sv

// ==== common/sdPkg.sv ====
/* SD host write path constants
   Frame widths, command indices, block geometry and FSM state codes */

package sdPkg;

    // ==============================
    // Command and response frames
    // ==============================
    localparam int frameBits    = 48;
    localparam int cmdArgBits   = 32;
    localparam int writeLenBits = 23;
    localparam int rcaBits      = 16;

    localparam logic [5:0] cmdAppCmd      = 6'd55;   // APP_CMD
    localparam logic [5:0] cmdSetBlkCount = 6'd23;   // ACMD23 pre-erase count
    localparam logic [5:0] cmdWriteMulti  = 6'd25;   // WRITE_MULTIPLE_BLOCK
    localparam logic [5:0] cmdStop        = 6'd12;   // STOP_TRANSMISSION

    // ==============================
    // Data blocks
    // ==============================
    localparam int blockNibbles  = 1024;
    localparam int wordsPerBlock = 256;
    localparam int crcNibbles    = 16;

    // Status bits of the card's CRC token
    localparam logic [2:0] crcTokenOk = 3'b010;

    // ==============================
    // FSM state codes
    // ==============================
    localparam logic [2:0] seqIdle = 3'd0, seqAppCmd = 3'd1, seqBlkCount = 3'd2;
    localparam logic [2:0] seqWriteMulti = 3'd3, seqBlock = 3'd4;
    localparam logic [2:0] seqStop = 3'd5, seqStopBusy = 3'd6;

    localparam logic [2:0] wrIdle = 3'd0, wrStart = 3'd1, wrData = 3'd2, wrCrc = 3'd3;
    localparam logic [2:0] wrEnd = 3'd4, wrTokWait = 3'd5, wrToken = 3'd6, wrBusy = 3'd7;

endpackage

// ==== flist.f ====
common/sdPkg.sv
src/sdCrc7.sv
src/sdCrc16.sv
sdCore/sdCmdLink.sv
sdCore/sdDatWriter.sv
sdCore/sdWriteSequencer.sv
src/sdHostTop.sv
verif/sdCardModel.sv
verif/tbSdHost.sv

// ==== sdCore/sdCmdLink.sv ====
/* SD command line engine
   Sends one 48-bit command with CRC7 and checks the R1 response frame */

`timescale 1ns/1ps

module sdCmdLink import sdPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cmdStart,
    input  logic [5:0]            cmdIndex,
    input  logic [cmdArgBits-1:0] cmdArg,
    output logic                  cmdDone,
    output logic                  respErr,
    input  logic                  sdCmdIn,
    output logic                  sdCmdOut,
    output logic                  sdCmdOutActive
);

    logic [frameBits-1:0] txReg;
    logic [frameBits-3:0] rxReg;
    logic [5:0]           bitCnt;
    logic                 rxWait;
    logic                 rxRun;
    logic                 rxStaged;
    logic [6:0]           txCrc;
    logic [6:0]           rxCrc;
    logic [6:0]           rxCrcNext;

    // ==============================
    // CRC generators
    // ==============================
    sdCrc7 txCrcGen (
        .clk    (clk),
        .clear  (!sdCmdOutActive),
        .din    (txReg[frameBits-1]),
        .crcNext(txCrc)
    );

    // Zero start bit leaves a cleared CRC unchanged
    sdCrc7 rxCrcGen (
        .clk    (clk),
        .clear  (!rxRun),
        .din    (rxStaged),
        .crcNext(rxCrcNext)
    );

    assign sdCmdOut = sdCmdOutActive ? txReg[frameBits-1] : 1'b1;

    // Last response bit sits in rxStaged while bitCnt is zero
    assign cmdDone = rxRun && (bitCnt == 6'd0);
    assign respErr = cmdDone && ((rxCrc != rxReg[6:0]) || rxReg[frameBits-3] || !rxStaged);

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sdCmdOutActive <= 1'b0;
            rxWait         <= 1'b0;
            rxRun          <= 1'b0;
        end else if (cmdStart) begin
            sdCmdOutActive <= 1'b1;
            rxWait         <= 1'b0;
            rxRun          <= 1'b0;
        end else if (sdCmdOutActive) begin
            if (bitCnt == 6'd0) begin
                sdCmdOutActive <= 1'b0;
                rxWait         <= 1'b1;
            end
        end else if (rxWait) begin
            if (!rxStaged) begin
                rxWait <= 1'b0;
                rxRun  <= 1'b1;
            end
        end else if (cmdDone) begin
            rxRun <= 1'b0;
        end
    end

    // ==============================
    // Shift registers
    // ==============================
    always_ff @(posedge clk) begin
        // Own transmission reads back as idle high
        rxStaged <= sdCmdOutActive ? 1'b1 : sdCmdIn;

        if (cmdStart) begin
            txReg  <= {2'b01, cmdIndex, cmdArg, 8'h01};
            bitCnt <= 6'(frameBits - 1);
        end else if (sdCmdOutActive) begin
            // Splice CRC7 and end bit once the argument is out
            if (bitCnt == 6'd8) begin
                txReg <= {txCrc, 1'b1, {(frameBits - 8){1'b0}}};
            end else begin
                txReg <= txReg << 1;
            end
            bitCnt <= bitCnt - 6'd1;
        end else if (rxWait) begin
            bitCnt <= 6'(frameBits - 2);
        end else if (rxRun) begin
            rxReg  <= {rxReg[frameBits-4:0], rxStaged};
            bitCnt <= bitCnt - 6'd1;
            if (bitCnt == 6'd8) begin
                rxCrc <= rxCrcNext;
            end
        end
    end

endmodule

// ==== sdCore/sdDatWriter.sv ====
/* SD data block writer
   Sends one block on DAT[3:0] with CRC16s, checks the CRC token, waits out busy */

`timescale 1ns/1ps

module sdDatWriter import sdPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        blockStart,
    input  logic [15:0] dataIn,
    output logic        dataInAccepted,
    input  logic [3:0]  sdDatIn,
    output logic [3:0]  sdDatOut,
    output logic        sdDatOutActive,
    output logic        blockDone,
    output logic        tokenErr,
    output logic        datBusy
);

    logic [2:0]  phase;
    logic [9:0]  nibCnt;
    logic [7:0]  wordCnt;
    logic [11:0] wordReg;
    logic [3:0]  crcCnt;
    logic [2:0]  tokReg;
    logic [1:0]  tokCnt;
    logic        loadWord;
    logic        lastNibble;
    logic [15:0] crcNext [4];
    logic [15:0] crcReg [4];
    logic [3:0]  crcTop;
    logic [3:0]  crcRegTop;

    // ==============================
    // Per-line CRC16
    // ==============================
    for (genvar i = 0; i < 4; i++) begin : gLine
        sdCrc16 crcGen (
            .clk    (clk),
            .clear  (phase != wrData),
            .din    (sdDatOut[i]),
            .crcNext(crcNext[i])
        );
        assign crcTop[i]    = crcNext[i][15];
        assign crcRegTop[i] = crcReg[i][15];
    end

    // Word fetch on the last nibble of the previous word
    assign loadWord = (phase == wrStart) ||
                      ((phase == wrData) && (nibCnt[1:0] == 2'd3) && (wordCnt != 8'd0));
    assign lastNibble = (phase == wrData) && (nibCnt == 10'(blockNibbles - 1));

    assign dataInAccepted = loadWord;
    assign tokenErr = (phase == wrToken) && (tokCnt == 2'd3) &&
                      ((tokReg != crcTokenOk) || !sdDatIn[0]);
    assign blockDone = (phase == wrBusy) && sdDatIn[0];
    assign datBusy = (phase == wrIdle) && !sdDatIn[0];

    // ==============================
    // Phase FSM and line drive
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase          <= wrIdle;
            sdDatOutActive <= 1'b0;
            sdDatOut       <= 4'hF;
        end else begin
            case (phase)
                wrIdle: begin
                    if (blockStart) begin
                        phase          <= wrStart;
                        sdDatOutActive <= 1'b1;
                        sdDatOut       <= 4'h0;
                    end
                end
                wrStart: begin
                    phase    <= wrData;
                    sdDatOut <= dataIn[15:12];
                end
                wrData: begin
                    if (lastNibble) begin
                        phase    <= wrCrc;
                        sdDatOut <= crcTop;
                    end else if (loadWord) begin
                        sdDatOut <= dataIn[15:12];
                    end else begin
                        sdDatOut <= wordReg[11:8];
                    end
                end
                wrCrc: begin
                    if (crcCnt == 4'(crcNibbles - 1)) begin
                        phase    <= wrEnd;
                        sdDatOut <= 4'hF;
                    end else begin
                        sdDatOut <= crcRegTop;
                    end
                end
                wrEnd: begin
                    phase          <= wrTokWait;
                    sdDatOutActive <= 1'b0;
                end
                wrTokWait: begin
                    if (!sdDatIn[0]) begin
                        phase <= wrToken;
                    end
                end
                wrToken: begin
                    if (tokCnt == 2'd3) begin
                        phase <= wrBusy;
                    end
                end
                default: begin
                    // Card holds DAT0 low while programming
                    if (sdDatIn[0]) begin
                        phase <= wrIdle;
                    end
                end
            endcase
        end
    end

    // ==============================
    // Counters and shift registers
    // ==============================
    always_ff @(posedge clk) begin
        if (loadWord) begin
            wordReg <= dataIn[11:0];
        end else begin
            wordReg <= wordReg << 4;
        end

        case (phase)
            wrIdle: begin
                nibCnt  <= '0;
                wordCnt <= 8'(wordsPerBlock - 1);
            end
            wrData: begin
                nibCnt <= nibCnt + 10'd1;
                if (loadWord) begin
                    wordCnt <= wordCnt - 8'd1;
                end
            end
            wrCrc: crcCnt <= crcCnt + 4'd1;
            wrTokWait: tokCnt <= '0;
            wrToken: begin
                tokReg <= {tokReg[1:0], sdDatIn[0]};
                tokCnt <= tokCnt + 2'd1;
            end
            default: ;
        endcase

        for (int i = 0; i < 4; i++) begin
            if (lastNibble) begin
                crcReg[i] <= {crcNext[i][14:0], 1'b0};
            end else if (phase == wrCrc) begin
                crcReg[i] <= crcReg[i] << 1;
            end
        end
        if (lastNibble) begin
            crcCnt <= '0;
        end
    end

endmodule

// ==== sdCore/sdWriteSequencer.sv ====
/* SD multi-block write sequencer
   Orders CMD55, ACMD23, CMD25, the data blocks and CMD12, holds the error flag */

`timescale 1ns/1ps

module sdWriteSequencer import sdPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [rcaBits-1:0]      rca,
    input  logic                    cmdTrigger,
    output logic                    cmdAccepted,
    input  logic [writeLenBits-1:0] cmdWriteLen,
    input  logic [cmdArgBits-1:0]   cmdAddr,
    output logic                    cmdStart,
    output logic [5:0]              cmdIndex,
    output logic [cmdArgBits-1:0]   cmdArg,
    input  logic                    cmdDone,
    input  logic                    respErr,
    output logic                    blockStart,
    input  logic                    blockDone,
    input  logic                    tokenErr,
    input  logic                    datBusy,
    output logic                    err
);

    logic [2:0]              state;
    logic [cmdArgBits-1:0]   addrReg;
    logic [writeLenBits-1:0] lenReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= seqIdle;
            cmdAccepted <= 1'b0;
            cmdStart    <= 1'b0;
            blockStart  <= 1'b0;
            err         <= 1'b0;
        end else begin
            // Single-cycle strobes by default
            cmdAccepted <= 1'b0;
            cmdStart    <= 1'b0;
            blockStart  <= 1'b0;

            if (respErr || tokenErr) begin
                err <= 1'b1;
            end

            case (state)
                seqIdle: begin
                    if (cmdTrigger) begin
                        addrReg     <= cmdAddr;
                        lenReg      <= cmdWriteLen;
                        cmdAccepted <= 1'b1;
                        cmdStart    <= 1'b1;
                        cmdIndex    <= cmdAppCmd;
                        cmdArg      <= {rca, {(cmdArgBits - rcaBits){1'b0}}};
                        state       <= seqAppCmd;
                    end
                end
                seqAppCmd: begin
                    if (cmdDone) begin
                        cmdStart <= 1'b1;
                        cmdIndex <= cmdSetBlkCount;
                        cmdArg   <= {{(cmdArgBits - writeLenBits){1'b0}}, lenReg};
                        state    <= seqBlkCount;
                    end
                end
                seqBlkCount: begin
                    if (cmdDone) begin
                        cmdStart <= 1'b1;
                        cmdIndex <= cmdWriteMulti;
                        cmdArg   <= addrReg;
                        state    <= seqWriteMulti;
                    end
                end
                seqWriteMulti: begin
                    if (cmdDone) begin
                        blockStart <= 1'b1;
                        state      <= seqBlock;
                    end
                end
                seqBlock: begin
                    // Trigger still high asks for one more block
                    if (blockDone) begin
                        cmdAccepted <= 1'b1;
                        if (cmdTrigger) begin
                            blockStart <= 1'b1;
                        end else begin
                            cmdStart <= 1'b1;
                            cmdIndex <= cmdStop;
                            cmdArg   <= '0;
                            state    <= seqStop;
                        end
                    end
                end
                seqStop: begin
                    if (cmdDone) begin
                        state <= seqStopBusy;
                    end
                end
                default: begin
                    if (!datBusy) begin
                        state <= seqIdle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/sdCrc16.sv ====
/* Serial CRC16-CCITT (x^16 + x^12 + x^5 + 1) for one SD data line */

`timescale 1ns/1ps

module sdCrc16 (
    input  logic        clk,
    input  logic        clear,
    input  logic        din,
    output logic [15:0] crcNext
);

    logic [15:0] crc;
    logic        feedback;

    assign feedback = din ^ crc[15];

    // Taps at bits 12, 5 and 0
    assign crcNext = {crc[14:12], crc[11] ^ feedback, crc[10:5],
                      crc[4] ^ feedback, crc[3:0], feedback};

    always_ff @(posedge clk) begin
        if (clear) begin
            crc <= '0;
        end else begin
            crc <= crcNext;
        end
    end

endmodule

// ==== src/sdCrc7.sv ====
/* Serial CRC7 (x^7 + x^3 + 1) for SD command and response frames */

`timescale 1ns/1ps

module sdCrc7 (
    input  logic       clk,
    input  logic       clear,
    input  logic       din,
    output logic [6:0] crcNext
);

    logic [6:0] crc;
    logic       feedback;

    assign feedback = din ^ crc[6];

    // Remainder with the current bit already folded in
    assign crcNext = {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};

    always_ff @(posedge clk) begin
        if (clear) begin
            crc <= '0;
        end else begin
            crc <= crcNext;
        end
    end

endmodule

// ==== src/sdHostTop.sv ====
/* SD host write path top
   Joins the write sequencer, command line engine and data writer */

`timescale 1ns/1ps

module sdHostTop import sdPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [rcaBits-1:0]      rca,
    input  logic                    cmdTrigger,
    output logic                    cmdAccepted,
    input  logic [writeLenBits-1:0] cmdWriteLen,
    input  logic [cmdArgBits-1:0]   cmdAddr,
    input  logic [15:0]             dataIn,
    output logic                    dataInAccepted,
    output logic                    err,
    input  logic                    sdCmdIn,
    output logic                    sdCmdOut,
    output logic                    sdCmdOutActive,
    input  logic [3:0]              sdDatIn,
    output logic [3:0]              sdDatOut,
    output logic                    sdDatOutActive
);

    logic                  cmdStart;
    logic [5:0]            cmdIndex;
    logic [cmdArgBits-1:0] cmdArg;
    logic                  cmdDone;
    logic                  respErr;
    logic                  blockStart;
    logic                  blockDone;
    logic                  tokenErr;
    logic                  datBusy;

    sdWriteSequencer sequencer (
        .clk(clk), .rstN(rstN), .rca(rca), .cmdTrigger(cmdTrigger),
        .cmdAccepted(cmdAccepted), .cmdWriteLen(cmdWriteLen), .cmdAddr(cmdAddr),
        .cmdStart(cmdStart), .cmdIndex(cmdIndex), .cmdArg(cmdArg),
        .cmdDone(cmdDone), .respErr(respErr), .blockStart(blockStart),
        .blockDone(blockDone), .tokenErr(tokenErr), .datBusy(datBusy), .err(err)
    );

    sdCmdLink cmdLink (
        .clk(clk), .rstN(rstN), .cmdStart(cmdStart), .cmdIndex(cmdIndex),
        .cmdArg(cmdArg), .cmdDone(cmdDone), .respErr(respErr), .sdCmdIn(sdCmdIn),
        .sdCmdOut(sdCmdOut), .sdCmdOutActive(sdCmdOutActive)
    );

    sdDatWriter datWriter (
        .clk(clk), .rstN(rstN), .blockStart(blockStart), .dataIn(dataIn),
        .dataInAccepted(dataInAccepted), .sdDatIn(sdDatIn), .sdDatOut(sdDatOut),
        .sdDatOutActive(sdDatOutActive), .blockDone(blockDone),
        .tokenErr(tokenErr), .datBusy(datBusy)
    );

endmodule

// ==== verif/sdCardModel.sv ====
/* Behavioural SD card for the write path
   Checks command frames and block data, returns R1 responses, CRC tokens and busy */

`timescale 1ns/1ps

module sdCardModel import sdPkg::*; (
    input  logic        clk,
    input  logic        sdCmdOut,
    input  logic        sdCmdOutActive,
    output logic        sdCmdIn,
    input  logic [3:0]  sdDatOut,
    input  logic        sdDatOutActive,
    output logic [3:0]  sdDatIn,
    input  logic        corruptResp,
    input  logic        corruptToken,
    output logic        cmdSeen,
    output logic [5:0]  seenIndex,
    output logic [31:0] seenArg,
    output logic        stopBusy,
    output logic        badFrame,
    output logic        badData,
    output logic        badCrc,
    output logic        badLen
);

    logic [15:0] expWords[$];
    logic        tokLine;

    assign sdDatIn = {3'b111, tokLine & !stopBusy};

    function automatic logic [6:0] calcCrc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int b = 39; b >= 0; b--) begin
            fb  = bits[b] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    function automatic logic [15:0] stepCrc16(input logic [15:0] crc, input logic bitIn);
        logic fb;
        fb = bitIn ^ crc[15];
        return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    endfunction

    // ==============================
    // Command line
    // ==============================
    initial begin
        logic [frameBits-1:0] frame;
        logic [frameBits-1:0] resp;
        logic [6:0]           crc;
        int                   cnt;
        sdCmdIn  = 1'b1;
        stopBusy = 1'b0;
        cmdSeen  = 1'b0;
        badFrame = 1'b0;
        forever begin
            cnt = 0;
            while (cnt < frameBits) begin
                @(posedge clk);
                if (sdCmdOutActive) begin
                    frame = {frame[frameBits-2:0], sdCmdOut};
                    cnt++;
                end
            end
            if (frame[47] || !frame[46] || !frame[0] || frame[7:1] != calcCrc7(frame[47:8]))
                badFrame = 1'b1;
            @(negedge clk);
            seenIndex = frame[45:40];
            seenArg   = frame[39:8];
            cmdSeen   = 1'b1;
            @(negedge clk);
            cmdSeen = 1'b0;
            repeat ($urandom_range(10, 2)) @(negedge clk);
            // R1 response echoes the index
            crc  = calcCrc7({2'b00, frame[45:40], 32'h0000_0900});
            crc  = corruptResp ? crc ^ 7'h01 : crc;
            resp = {2'b00, frame[45:40], 32'h0000_0900, crc, 1'b1};
            for (int b = frameBits - 1; b >= 0; b--) begin
                sdCmdIn = resp[b];
                if (b == 0 && frame[45:40] == cmdStop)
                    stopBusy = 1'b1;
                @(negedge clk);
            end
            sdCmdIn = 1'b1;
            if (stopBusy) begin
                repeat ($urandom_range(40, 5)) @(negedge clk);
                stopBusy = 1'b0;
            end
        end
    end

    // ==============================
    // Data lines
    // ==============================
    initial begin
        logic [15:0] crc [4];
        logic [15:0] word;
        logic [15:0] expWord;
        int          idx;
        int          words;
        tokLine = 1'b1;
        badData = 1'b0;
        badCrc  = 1'b0;
        badLen  = 1'b0;
        idx     = 0;
        words   = 0;
        forever begin
            @(posedge clk);
            if (sdDatOutActive) begin
                if (idx == 0) begin
                    if (sdDatOut != 4'h0) badLen = 1'b1;
                    for (int i = 0; i < 4; i++) crc[i] = '0;
                    words = 0;
                end else if (idx <= blockNibbles) begin
                    for (int i = 0; i < 4; i++) crc[i] = stepCrc16(crc[i], sdDatOut[i]);
                    word = {word[11:0], sdDatOut};
                    if (idx % 4 == 0) begin
                        if (expWords.size() == 0) begin
                            badData = 1'b1;
                        end else begin
                            expWord = expWords.pop_front();
                            if (word != expWord) badData = 1'b1;
                        end
                        words++;
                    end
                end else if (idx <= blockNibbles + crcNibbles) begin
                    for (int i = 0; i < 4; i++)
                        if (sdDatOut[i] != crc[i][15 - (idx - blockNibbles - 1)]) badCrc = 1'b1;
                end else if (sdDatOut != 4'hF) begin
                    badLen = 1'b1;
                end
                idx++;
            end else if (idx != 0) begin
                // Every accepted word of the block must have gone out on the bus
                if (idx != blockNibbles + crcNibbles + 2 || words != wordsPerBlock ||
                    expWords.size() != 0)
                    badLen = 1'b1;
                idx = 0;
                // Token, then programming busy
                @(negedge clk);
                word = {11'h0, 1'b0, corruptToken ? 3'b101 : crcTokenOk, 1'b1};
                for (int b = 4; b >= 0; b--) begin
                    tokLine = word[b];
                    @(negedge clk);
                end
                tokLine = 1'b0;
                repeat ($urandom_range(40, 5)) @(negedge clk);
                tokLine = 1'b1;
            end
        end
    end

endmodule

// ==== verif/tbSdHost.sv ====
/* Testbench for the SD host write path
   Runs multi-block writes against the card model and checks with assertions */

`timescale 1ns/1ps

module tbSdHost import sdPkg::*; ();

    localparam int totalBlocks = 6;
    localparam int watchdogCycles = totalBlocks * 1500 + 20000;

    logic clk = 1'b0, rstN, cmdTrigger, cmdAccepted, dataInAccepted, err;
    logic [rcaBits-1:0] rca;
    logic [writeLenBits-1:0] cmdWriteLen;
    logic [cmdArgBits-1:0] cmdAddr;
    logic [15:0] dataIn;
    logic sdCmdIn, sdCmdOut, sdCmdOutActive, sdDatOutActive;
    logic [3:0] sdDatIn, sdDatOut;
    logic corruptResp, corruptToken, cmdSeen, stopBusy;
    logic badFrame, badData, badCrc, badLen;
    logic [5:0] seenIndex;
    logic [31:0] seenArg;
    logic wordTaken = 1'b0;
    logic errAllowed = 1'b0;
    int acceptCount = 0;
    int cmdStep = 0;

    always #4 clk = ~clk;

    sdHostTop uut (.*);

    sdCardModel card (.*);

    task automatic stopOnError(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // ==============================
    // Expected command stream
    // ==============================
    function automatic logic [5:0] expectedIndex(input int step);
        case (step)
            0: return cmdAppCmd;
            1: return cmdSetBlkCount;
            2: return cmdWriteMulti;
            default: return cmdStop;
        endcase
    endfunction

    function automatic logic [31:0] expectedArg(input int step);
        case (step)
            0: return {rca, 16'h0000};
            1: return {9'h000, cmdWriteLen};
            2: return cmdAddr;
            default: return 32'h0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (cmdSeen) cmdStep = cmdStep + 1;
        if (cmdAccepted) acceptCount = acceptCount + 1;
        if (dataInAccepted) begin
            card.expWords.push_back(dataIn);
            wordTaken = 1'b1;
        end
    end

    // New word only after the accepting edge
    always @(negedge clk) begin
        if (wordTaken) begin
            dataIn    = 16'($urandom);
            wordTaken = 1'b0;
        end
    end

    aFrame: assert property (@(posedge clk) !badFrame) else stopOnError("bad command frame");
    aData: assert property (@(posedge clk) !badData) else stopOnError("block data mismatch");
    aCrc: assert property (@(posedge clk) !badCrc) else stopOnError("data CRC16 mismatch");
    aLen: assert property (@(posedge clk) !badLen) else stopOnError("block framing or length");
    aCmd: assert property (@(posedge clk) cmdSeen |->
            seenIndex == expectedIndex(cmdStep) && seenArg == expectedArg(cmdStep))
        else stopOnError("wrong command index or argument");
    aNoBlock: assert property (@(posedge clk) cmdStep >= 4 |-> !$rose(sdDatOutActive))
        else stopOnError("block started after CMD12");
    aBusyIdle: assert property (@(posedge clk) cmdAccepted |-> !stopBusy)
        else stopOnError("request accepted while card busy");
    aErrLow: assert property (@(posedge clk) disable iff (!rstN) !errAllowed |-> !err)
        else stopOnError("err set on a clean transfer");
    aErrHold: assert property (@(posedge clk) $fell(err) |-> !$past(rstN))
        else stopOnError("err cleared without reset");

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic runTransfer(input int blocks);
        @(negedge clk);
        acceptCount = 0;
        cmdStep     = 0;
        rca         = 16'($urandom);
        cmdAddr     = $urandom;
        cmdWriteLen = 23'(blocks);
        cmdTrigger  = 1'b1;
        wait (acceptCount == blocks);
        @(negedge clk);
        cmdTrigger = 1'b0;
        wait (cmdStep == 4);
        assert (acceptCount == blocks + 1) else stopOnError("wrong cmdAccepted count");
    endtask

    task automatic finishTransfer();
        wait (stopBusy);
        wait (!stopBusy);
        repeat (4) @(negedge clk);
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: the write sequence did not complete");
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hcd72));
        rstN = 1'b0;
        cmdTrigger = 1'b0;
        rca = '0;
        cmdAddr = '0;
        cmdWriteLen = '0;
        dataIn = 16'($urandom);
        corruptResp = 1'b0;
        corruptToken = 1'b0;
        applyReset();
        // Second request is raised during CMD12 busy
        runTransfer(3);
        runTransfer(1);
        finishTransfer();
        errAllowed = 1'b1;
        corruptResp = 1'b1;
        runTransfer(1);
        finishTransfer();
        corruptResp = 1'b0;
        assert (err) else stopOnError("err not set by bad response CRC");
        applyReset();
        @(negedge clk);
        assert (!err) else stopOnError("err not cleared by reset");
        corruptToken = 1'b1;
        runTransfer(1);
        finishTransfer();
        corruptToken = 1'b0;
        assert (err) else stopOnError("err not set by bad CRC token");
        applyReset();
        @(negedge clk);
        assert (!err) else stopOnError("err not cleared by reset");
        $display("*** PASSED ***");
        $finish;
    end

endmodule
